// ==== rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// number of reorder buffer entries, a power of two
`define ROB_DEPTH 16

// entry index width, the wrap bit sits on top of this
`define ROB_IDX_W $clog2(`ROB_DEPTH)

// instructions accepted from dispatch per cycle
`define DISP_W 2

// instructions retired from the head per cycle
`define RET_W 2

// pc and branch target width
`define PC_W 32

// exception cause code width inside the event word
`define CAUSE_W 5

`endif

// ==== rob_pkg.sv ====
`include "rob_params.svh"

package rob_pkg;

    // wrap bit flips each time a pointer passes the end of the buffer
    // so two indices can be ordered by age
    typedef struct packed {
        logic                  wrap;
        logic [`ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    // selects the view of the event word
    typedef enum logic {
        wb_branch,
        wb_except
    } wb_kind_e;

    // one event word, read as branch or as exception info
    typedef union packed {
        // pc bits [1:0] are always zero, so npc holds pc[PC_W-1:2]
        struct packed {
            logic             taken;
            logic             mispred;
            logic [`PC_W-3:0] npc;
        } branch_info;
        // tval keeps whatever fits next to the cause code
        struct packed {
            logic [`CAUSE_W-1:0]       cause;
            logic [`PC_W-`CAUSE_W-1:0] tval;
        } except_info;
    } wb_payload_u;

    // reason for a pipeline squash
    typedef enum logic {
        sq_branch,
        sq_trap
    } squash_cause_e;

endpackage

// ==== rob_entry_queue.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_entry_queue (
    input  logic                            clk,
    input  logic                            rst,
    // dispatch side
    input  logic                            i_enq_vld,
    input  logic [`DISP_W-1:0]              i_enq_mask,
    input  logic [`DISP_W-1:0][`PC_W-1:0]   i_enq_pc,
    output logic                            o_can_enq,
    output rob_pkg::rob_idx_t [`DISP_W-1:0] o_alloc_idx,
    // writeback side
    input  logic                            i_done_vld,
    input  rob_pkg::rob_idx_t               i_done_idx,
    input  logic                            i_evt_vld,
    input  rob_pkg::rob_idx_t               i_evt_idx,
    // from the commit selector
    input  logic [`RET_W-1:0]               i_ret_mask,
    input  logic                            i_flush,
    // oldest entries
    output logic [`RET_W-1:0]               o_head_vld,
    output rob_pkg::rob_idx_t [`RET_W-1:0]  o_head_idx,
    output logic [`RET_W-1:0][`PC_W-1:0]    o_head_pc
);

    // per entry pc, written on allocation only
    logic [`PC_W-1:0]      pc_mem [`ROB_DEPTH];
    // per entry completion flag
    logic [`ROB_DEPTH-1:0] done_q;
    // pointers carry the wrap bit in the msb
    logic [`ROB_IDX_W:0]   head_q;
    logic [`ROB_IDX_W:0]   tail_q;
    // occupancy, 0 up to ROB_DEPTH
    logic [`ROB_IDX_W:0]   count_q;
    logic [`ROB_IDX_W:0]   free_cnt;
    logic [`ROB_IDX_W:0]   enq_cnt;
    logic [`ROB_IDX_W:0]   ret_cnt;
    logic                  enq_fire;

    assign free_cnt = (`ROB_IDX_W+1)'(`ROB_DEPTH) - count_q;

    // a full dispatch group must fit, nothing is taken during a flush
    assign o_can_enq = (free_cnt >= `DISP_W) && !i_flush;
    assign enq_fire  = i_enq_vld && o_can_enq;

    // masks are contiguous from bit 0, so a popcount gives the step
    always_comb begin
        enq_cnt = '0;
        ret_cnt = '0;
        for (int s = 0; s < `DISP_W; s++) begin
            if (i_enq_mask[s]) begin
                enq_cnt = enq_cnt + 1'b1;
            end
        end
        for (int r = 0; r < `RET_W; r++) begin
            if (i_ret_mask[r]) begin
                ret_cnt = ret_cnt + 1'b1;
            end
        end
    end

    // slot s lands at tail + s
    for (genvar s = 0; s < `DISP_W; s++) begin : g_alloc
        assign o_alloc_idx[s] = tail_q + (`ROB_IDX_W+1)'(s);
    end

    // head window, valid only inside the occupied range and once done
    for (genvar k = 0; k < `RET_W; k++) begin : g_head
        logic [`ROB_IDX_W:0] win_idx;
        assign win_idx       = head_q + (`ROB_IDX_W+1)'(k);
        assign o_head_idx[k] = win_idx;
        assign o_head_pc[k]  = pc_mem[win_idx[`ROB_IDX_W-1:0]];
        assign o_head_vld[k] = (count_q > k) && done_q[win_idx[`ROB_IDX_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            // squash drops every entry and restarts at index 0
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (i_done_vld) begin
                done_q[i_done_idx.idx] <= 1'b1;
            end
            // an event counts as completion too
            if (i_evt_vld) begin
                done_q[i_evt_idx.idx] <= 1'b1;
            end
            if (enq_fire) begin
                for (int s = 0; s < `DISP_W; s++) begin
                    if (i_enq_mask[s]) begin
                        done_q[o_alloc_idx[s].idx] <= 1'b0;
                    end
                end
                tail_q <= tail_q + enq_cnt;
            end
            head_q  <= head_q + ret_cnt;
            count_q <= count_q + (enq_fire ? enq_cnt : '0) - ret_cnt;
        end
    end

    // pc storage
    always_ff @(posedge clk) begin
        for (int s = 0; s < `DISP_W; s++) begin
            if (enq_fire && i_enq_mask[s]) begin
                pc_mem[o_alloc_idx[s].idx] <= i_enq_pc[s];
            end
        end
    end

endmodule

// ==== rob_event_tracker.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_event_tracker (
    input  logic                   clk,
    input  logic                   rst,
    // event port
    input  logic                   i_evt_vld,
    input  rob_pkg::rob_idx_t      i_evt_idx,
    input  rob_pkg::wb_kind_e      i_evt_kind,
    input  rob_pkg::wb_payload_u   i_evt_word,
    // oldest index in the buffer, the age reference
    input  rob_pkg::rob_idx_t      i_head_idx,
    input  logic                   i_flush,
    // oldest mispredicted branch
    output logic                   o_br_vld,
    output rob_pkg::rob_idx_t      o_br_idx,
    output logic [`PC_W-1:0]       o_br_npc,
    output logic                   o_br_taken,
    // oldest exception
    output logic                   o_ex_vld,
    output rob_pkg::rob_idx_t      o_ex_idx,
    output logic [`CAUSE_W-1:0]    o_ex_cause
);

    logic                br_evt;
    logic                ex_evt;
    // distance from the head, smaller means older
    logic [`ROB_IDX_W:0] evt_age;
    logic [`ROB_IDX_W:0] br_age;
    logic [`ROB_IDX_W:0] ex_age;

    // only a mispredict matters here, correct branches just complete
    assign br_evt = i_evt_vld && (i_evt_kind == rob_pkg::wb_branch)
                    && i_evt_word.branch_info.mispred;
    assign ex_evt = i_evt_vld && (i_evt_kind == rob_pkg::wb_except);

    // full-width subtract folds the wrap bit into the distance
    assign evt_age = i_evt_idx - i_head_idx;
    assign br_age  = o_br_idx - i_head_idx;
    assign ex_age  = o_ex_idx - i_head_idx;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            o_br_vld <= 1'b0;
            o_ex_vld <= 1'b0;
        end else begin
            // keep the older one
            if (br_evt && (!o_br_vld || (evt_age < br_age))) begin
                o_br_vld   <= 1'b1;
                o_br_idx   <= i_evt_idx;
                o_br_npc   <= {i_evt_word.branch_info.npc, 2'b00};
                o_br_taken <= i_evt_word.branch_info.taken;
            end
            if (ex_evt && (!o_ex_vld || (evt_age < ex_age))) begin
                o_ex_vld   <= 1'b1;
                o_ex_idx   <= i_evt_idx;
                o_ex_cause <= i_evt_word.except_info.cause;
            end
        end
    end

endmodule

// ==== rob_commit_select.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_commit_select (
    input  logic                           clk,
    input  logic                           rst,
    // head window from the queue
    input  logic [`RET_W-1:0]              i_head_vld,
    input  rob_pkg::rob_idx_t [`RET_W-1:0] i_head_idx,
    input  logic [`RET_W-1:0][`PC_W-1:0]   i_head_pc,
    // tracked events
    input  logic                           i_br_vld,
    input  rob_pkg::rob_idx_t              i_br_idx,
    input  logic [`PC_W-1:0]               i_br_npc,
    input  logic                           i_br_taken,
    input  logic                           i_ex_vld,
    input  rob_pkg::rob_idx_t              i_ex_idx,
    input  logic [`CAUSE_W-1:0]            i_ex_cause,
    input  logic [`PC_W-1:0]               i_trap_vec,
    // retirement and pipeline control
    output logic [`RET_W-1:0]              o_ret_mask,
    output logic                           o_flush,
    output logic                           o_squash_vld,
    output rob_pkg::squash_cause_e         o_squash_cause,
    output logic [`PC_W-1:0]               o_squash_pc,
    output logic                           o_squash_taken,
    output logic [`PC_W-1:0]               o_trap_epc,
    output logic [`CAUSE_W-1:0]            o_trap_cause
);

    // high for the one cycle between the exception at head and the squash
    logic             trap_q;
    logic             squash_q;
    logic             walk_ok;
    logic             br_hit;
    logic             ex_hit;
    logic [`PC_W-1:0] ex_pc;

    // walk the head window oldest first
    // the first of mispredict and exception on the way decides
    always_comb begin
        walk_ok    = !trap_q && !squash_q;
        br_hit     = 1'b0;
        ex_hit     = 1'b0;
        ex_pc      = i_head_pc[0];
        o_ret_mask = '0;
        for (int k = 0; k < `RET_W; k++) begin
            if (walk_ok && i_head_vld[k]) begin
                if (i_ex_vld && (i_head_idx[k] == i_ex_idx)) begin
                    // faulting entry stays, older ones already retire
                    ex_hit  = 1'b1;
                    ex_pc   = i_head_pc[k];
                    walk_ok = 1'b0;
                end else begin
                    o_ret_mask[k] = 1'b1;
                    // the branch retires itself, nothing younger follows
                    if (i_br_vld && (i_head_idx[k] == i_br_idx)) begin
                        br_hit  = 1'b1;
                        walk_ok = 1'b0;
                    end
                end
            end else begin
                // in-order: a gap stops the walk
                walk_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trap_q   <= 1'b0;
            squash_q <= 1'b0;
        end else begin
            squash_q <= 1'b0;
            if (trap_q) begin
                // second trap cycle, redirect to the handler
                trap_q         <= 1'b0;
                squash_q       <= 1'b1;
                o_squash_cause <= rob_pkg::sq_trap;
                o_squash_pc    <= i_trap_vec;
                o_squash_taken <= 1'b0;
            end else if (ex_hit) begin
                trap_q       <= 1'b1;
                o_trap_epc   <= ex_pc;
                o_trap_cause <= i_ex_cause;
            end else if (br_hit) begin
                squash_q       <= 1'b1;
                o_squash_cause <= rob_pkg::sq_branch;
                o_squash_pc    <= i_br_npc;
                o_squash_taken <= i_br_taken;
            end
        end
    end

    // queue and tracker clear on the edge that ends the pulse
    assign o_squash_vld = squash_q;
    assign o_flush      = squash_q;

endmodule

// ==== rob_top.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_enq_vld,
    input  logic [`DISP_W-1:0]              i_enq_mask,
    input  logic [`DISP_W-1:0][`PC_W-1:0]   i_enq_pc,
    output logic                            o_can_enq,
    output rob_pkg::rob_idx_t [`DISP_W-1:0] o_alloc_idx,
    input  logic                            i_done_vld,
    input  rob_pkg::rob_idx_t               i_done_idx,
    input  logic                            i_evt_vld,
    input  rob_pkg::rob_idx_t               i_evt_idx,
    input  rob_pkg::wb_kind_e               i_evt_kind,
    input  rob_pkg::wb_payload_u            i_evt_word,
    input  logic [`PC_W-1:0]                i_trap_vec,
    output logic [`RET_W-1:0]               o_ret_mask,
    output logic                            o_squash_vld,
    output rob_pkg::squash_cause_e          o_squash_cause,
    output logic [`PC_W-1:0]                o_squash_pc,
    output logic                            o_squash_taken,
    output logic [`PC_W-1:0]                o_trap_epc,
    output logic [`CAUSE_W-1:0]             o_trap_cause
);

    // head window
    logic [`RET_W-1:0]              head_vld;
    rob_pkg::rob_idx_t [`RET_W-1:0] head_idx;
    logic [`RET_W-1:0][`PC_W-1:0]   head_pc;
    // tracker state
    logic                           br_vld;
    rob_pkg::rob_idx_t              br_idx;
    logic [`PC_W-1:0]               br_npc;
    logic                           br_taken;
    logic                           ex_vld;
    rob_pkg::rob_idx_t              ex_idx;
    logic [`CAUSE_W-1:0]            ex_cause;
    logic                           flush;

    // stage 1, entry storage
    rob_entry_queue u_queue (
        .*,
        .i_ret_mask (o_ret_mask),
        .i_flush    (flush),
        .o_head_vld (head_vld),
        .o_head_idx (head_idx),
        .o_head_pc  (head_pc)
    );

    // stage 2, age is measured from the oldest slot
    rob_event_tracker u_tracker (
        .*,
        .i_head_idx (head_idx[0]),
        .i_flush    (flush),
        .o_br_vld   (br_vld),
        .o_br_idx   (br_idx),
        .o_br_npc   (br_npc),
        .o_br_taken (br_taken),
        .o_ex_vld   (ex_vld),
        .o_ex_idx   (ex_idx),
        .o_ex_cause (ex_cause)
    );

    // stage 3, retire and squash
    rob_commit_select u_select (
        .*,
        .i_head_vld (head_vld),
        .i_head_idx (head_idx),
        .i_head_pc  (head_pc),
        .i_br_vld   (br_vld),
        .i_br_idx   (br_idx),
        .i_br_npc   (br_npc),
        .i_br_taken (br_taken),
        .i_ex_vld   (ex_vld),
        .i_ex_idx   (ex_idx),
        .i_ex_cause (ex_cause),
        .o_flush    (flush)
    );

endmodule

// ==== rob_assert.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_assert (
    input logic              clk,
    input logic              rst,
    input logic [`RET_W-1:0] i_ret_mask,
    input logic              i_squash_vld,
    input logic              i_trap
);

    // number of failed properties so far
    int fail_cnt = 0;

    // retired slots form one run from the oldest slot
    a_mask_contig: assert property (@(posedge clk) disable iff (rst)
        ((i_ret_mask + 1'b1) & i_ret_mask) == '0)
        else begin
            $error("retire mask is not contiguous from bit 0");
            fail_cnt = fail_cnt + 1;
        end

    a_squash_pulse: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |=> !i_squash_vld)
        else begin
            $error("squash stayed high for more than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    // trap state stalls the head
    a_trap_stall: assert property (@(posedge clk) disable iff (rst)
        i_trap |-> (i_ret_mask == '0))
        else begin
            $error("entries retired while in the trap state");
            fail_cnt = fail_cnt + 1;
        end

    // registers are cleared after the first reset edge
    a_reset_quiet: assert property (@(posedge clk)
        rst ##1 rst |-> (i_ret_mask == '0) && !i_squash_vld)
        else begin
            $error("retirement or squash active during reset");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind rob_commit_select rob_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .i_ret_mask   (o_ret_mask),
    .i_squash_vld (o_squash_vld),
    .i_trap       (trap_q)
);

// ==== rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_tb;

    // event codes used in the table
    localparam int evt_none = 0;
    localparam int evt_br   = 1;
    localparam int evt_ex   = 2;
    // expected squash in a row
    localparam int exp_none   = 0;
    localparam int exp_branch = 1;
    localparam int exp_trap   = 2;

    logic                            clk;
    logic                            rst;
    logic                            i_enq_vld;
    logic [`DISP_W-1:0]              i_enq_mask;
    logic [`DISP_W-1:0][`PC_W-1:0]   i_enq_pc;
    logic                            o_can_enq;
    rob_pkg::rob_idx_t [`DISP_W-1:0] o_alloc_idx;
    logic                            i_done_vld;
    rob_pkg::rob_idx_t               i_done_idx;
    logic                            i_evt_vld;
    rob_pkg::rob_idx_t               i_evt_idx;
    rob_pkg::wb_kind_e               i_evt_kind;
    rob_pkg::wb_payload_u            i_evt_word;
    logic [`PC_W-1:0]                i_trap_vec;
    logic [`RET_W-1:0]               o_ret_mask;
    logic                            o_squash_vld;
    rob_pkg::squash_cause_e          o_squash_cause;
    logic [`PC_W-1:0]                o_squash_pc;
    logic                            o_squash_taken;
    logic [`PC_W-1:0]                o_trap_epc;
    logic [`CAUSE_W-1:0]             o_trap_cause;

    // each queue holds one entry per row and one row is applied per cycle
    int                t_enq[$];
    logic [`PC_W-1:0]  t_pc[$];
    int                t_done[$];
    int                t_evt[$];
    int                t_evt_idx[$];
    logic [`PC_W-1:0]  t_evt_val[$];
    logic [`RET_W-1:0] t_mask[$];
    bit                t_can[$];
    int                t_sq[$];
    logic [`PC_W-1:0]  t_exp_pc[$];

    int seed;
    int cur_row    = 0;
    int cycle_cnt  = 0;
    int max_cycles = 1000;

    // taken bit of the next reported branch and of the last one
    bit                  next_taken;
    bit                  exp_taken;
    // cause code of the last reported exception
    logic [`CAUSE_W-1:0] exp_cause;
    // where the next dispatch group is expected to land
    rob_pkg::rob_idx_t   exp_tail;

    rob_top uut (.*);

    always #10 clk = ~clk;

    // watchdog on the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the table did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "run aborted by the cycle limit");
        end
    end

    task automatic stop_on_mismatch(input string name, input logic [`PC_W-1:0] exp,
                                    input logic [`PC_W-1:0] act);
        $display("** Error: %s row %0d expected %h actual %h", name, cur_row, exp, act);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_on_assert();
        $display("a bound assertion in the commit selector failed");
        $display("TEST FAILED");
        $fatal(1, "stopped on an assertion failure");
    endtask

    task automatic compare_mask(input string name, input logic [`RET_W-1:0] exp,
                                input logic [`RET_W-1:0] act);
        if (act !== exp) begin
            stop_on_mismatch(name, `PC_W'(exp), `PC_W'(act));
        end
    endtask

    task automatic verify_cause(input string name, input rob_pkg::squash_cause_e exp,
                                input rob_pkg::squash_cause_e act);
        if (act !== exp) begin
            stop_on_mismatch(name, `PC_W'(exp), `PC_W'(act));
        end
    endtask

    task automatic match_pc(input string name, input logic [`PC_W-1:0] exp,
                            input logic [`PC_W-1:0] act);
        if (act !== exp) begin
            stop_on_mismatch(name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_mismatch(name, `PC_W'(exp), `PC_W'(act));
        end
    endtask

    task automatic code_equal(input string name, input logic [`CAUSE_W-1:0] exp,
                              input logic [`CAUSE_W-1:0] act);
        if (act !== exp) begin
            stop_on_mismatch(name, `PC_W'(exp), `PC_W'(act));
        end
    endtask

    task automatic idx_equal(input string name, input rob_pkg::rob_idx_t exp,
                             input rob_pkg::rob_idx_t act);
        if (act !== exp) begin
            stop_on_mismatch(name, `PC_W'(exp), `PC_W'(act));
        end
    endtask

    // enq count, pc of slot 0, done index, event, expected mask, can_enq, squash
    task automatic add_row(input int enq, input logic [`PC_W-1:0] pc, input int done,
                           input int evt, input int evt_idx, input logic [`PC_W-1:0] val,
                           input logic [`RET_W-1:0] mask, input bit can, input int sq,
                           input logic [`PC_W-1:0] exp_pc);
        t_enq.push_back(enq);
        t_pc.push_back(pc);
        t_done.push_back(done);
        t_evt.push_back(evt);
        t_evt_idx.push_back(evt_idx);
        t_evt_val.push_back(val);
        t_mask.push_back(mask);
        t_can.push_back(can);
        t_sq.push_back(sq);
        t_exp_pc.push_back(exp_pc);
    endtask

    task automatic build_table();
        // out of order completion retires in order two at a time
        add_row(2, 'h100, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h108, 1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 3, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 2, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 0, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b11, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b11, 1, exp_none, 0);
        // fill all 16 entries from index 4 so the pointers wrap
        add_row(2, 'h200, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h208, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h210, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h218, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h220, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h228, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h230, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h238, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        // the full buffer holds the request until two slots free up
        add_row(2, 'h240, 4, evt_none, 0, 0, 2'b00, 0, exp_none, 0);
        add_row(2, 'h240, 5, evt_none, 0, 0, 2'b01, 0, exp_none, 0);
        add_row(2, 'h240, -1, evt_none, 0, 0, 2'b01, 0, exp_none, 0);
        add_row(2, 'h240, 8, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        // mispredict on 7 while entry 8 is done but must stay
        add_row(0, 0, 6, evt_none, 0, 0, 2'b00, 0, exp_none, 0);
        add_row(0, 0, -1, evt_br, 7, 'h300, 2'b01, 0, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b01, 0, exp_none, 0);
        // enqueue in the squash cycle is dropped
        add_row(2, 'h400, -1, evt_none, 0, 0, 2'b00, 0, exp_branch, 'h300);
        add_row(2, 'h400, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        // exception on index 1 lets only index 0 retire
        add_row(2, 'h408, -1, evt_ex, 1, 5, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 0, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b01, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 0, exp_trap, 'h404);
        // younger mispredict reported first loses to the older exception
        add_row(2, 'h500, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h508, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_br, 2, 'h600, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_ex, 1, 2, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 0, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b01, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 0, exp_trap, 'h504);
        // exception reported before the younger mispredict
        add_row(2, 'h700, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h708, -1, evt_ex, 1, 3, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_br, 2, 'h800, 2'b00, 1, exp_none, 0);
        add_row(0, 0, 0, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b01, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 0, exp_trap, 'h704);
        // mispredict older than the exception gives a branch squash
        add_row(2, 'h900, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
        add_row(2, 'h908, -1, evt_ex, 1, 4, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_br, 0, 'ha00, 2'b00, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b01, 1, exp_none, 0);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 0, exp_branch, 'ha00);
        add_row(0, 0, -1, evt_none, 0, 0, 2'b00, 1, exp_none, 0);
    endtask

    task automatic drive_row(input int r);
        rob_pkg::wb_payload_u word;
        logic [`PC_W-1:0]     val;
        word       = '0;
        val        = t_evt_val[r];
        i_enq_vld  = (t_enq[r] != 0);
        i_enq_mask = `DISP_W'((1 << t_enq[r]) - 1);
        // slots hold consecutive instructions
        for (int s = 0; s < `DISP_W; s++) begin
            i_enq_pc[s] = t_pc[r] + `PC_W'(4 * s);
        end
        i_done_vld = (t_done[r] >= 0);
        i_done_idx = (`ROB_IDX_W+1)'(t_done[r]);
        i_evt_vld  = (t_evt[r] != evt_none);
        i_evt_idx  = (`ROB_IDX_W+1)'(t_evt_idx[r]);
        if (t_evt[r] == evt_ex) begin
            i_evt_kind             = rob_pkg::wb_except;
            word.except_info.cause = val[`CAUSE_W-1:0];
            // a trap reports the cause of its faulting entry
            exp_cause              = val[`CAUSE_W-1:0];
        end else begin
            i_evt_kind               = rob_pkg::wb_branch;
            word.branch_info.mispred = (t_evt[r] == evt_br);
            // low pc bits are dropped from the word
            word.branch_info.npc     = val[`PC_W-1:2];
            if (t_evt[r] == evt_br) begin
                // taken alternates between reported branches
                word.branch_info.taken = next_taken;
                exp_taken              = next_taken;
                next_taken             = !next_taken;
            end
        end
        i_evt_word = word;
    endtask

    task automatic score_row(input int r);
        compare_mask("o_ret_mask", t_mask[r], o_ret_mask);
        check_flag("o_can_enq", t_can[r], o_can_enq);
        // slot s of the next group lands at tail + s
        for (int s = 0; s < `DISP_W; s++) begin
            idx_equal("o_alloc_idx", exp_tail + (`ROB_IDX_W+1)'(s), o_alloc_idx[s]);
        end
        check_flag("o_squash_vld", t_sq[r] != exp_none, o_squash_vld);
        if (t_sq[r] == exp_branch) begin
            verify_cause("o_squash_cause", rob_pkg::sq_branch, o_squash_cause);
            match_pc("o_squash_pc", t_exp_pc[r], o_squash_pc);
            check_flag("o_squash_taken", exp_taken, o_squash_taken);
        end else if (t_sq[r] == exp_trap) begin
            verify_cause("o_squash_cause", rob_pkg::sq_trap, o_squash_cause);
            match_pc("o_squash_pc", i_trap_vec, o_squash_pc);
            // faulting pc is still held during the pulse
            match_pc("o_trap_epc", t_exp_pc[r], o_trap_epc);
            code_equal("o_trap_cause", exp_cause, o_trap_cause);
        end
    endtask

    // tail moves by each accepted group and restarts at 0 after a squash
    task automatic step_tail(input int r);
        if (t_sq[r] != exp_none) begin
            exp_tail = '0;
        end else if (t_can[r] && (t_enq[r] != 0)) begin
            exp_tail = exp_tail + (`ROB_IDX_W+1)'(t_enq[r]);
        end
    endtask

    initial begin
        seed       = 11;
        next_taken = 1'b1;
        exp_taken  = 1'b0;
        exp_cause  = '0;
        exp_tail   = '0;
        clk        = 1'b0;
        rst        = 1'b1;
        i_enq_vld  = 1'b0;
        i_enq_mask = '0;
        i_enq_pc   = '0;
        i_done_vld = 1'b0;
        i_done_idx = '0;
        i_evt_vld  = 1'b0;
        i_evt_idx  = '0;
        i_evt_kind = rob_pkg::wb_branch;
        i_evt_word = '0;
        // handler address is word aligned
        i_trap_vec = $random(seed) & 32'hffff_fffc;
        build_table();
        max_cycles = t_enq.size() + 20;
        repeat (8) @(posedge clk);
        for (int r = 0; r < t_enq.size(); r++) begin
            #2;
            rst     = 1'b0;
            cur_row = r;
            drive_row(r);
            // outputs settle long before the falling edge
            @(negedge clk);
            score_row(r);
            if (uut.u_select.u_assert.fail_cnt != 0) begin
                abort_on_assert();
            end
            step_tail(r);
            @(posedge clk);
        end
        // the last edge is checked by the bound assertions too
        @(negedge clk);
        if (uut.u_select.u_assert.fail_cnt != 0) begin
            abort_on_assert();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== rob.f ====
+incdir+.
rob_pkg.sv
rob_entry_queue.sv
rob_event_tracker.sv
rob_commit_select.sv
rob_top.sv
rob_assert.sv
rob_tb.sv
